// ==== hdl/qla_pkg.sv ====
package qla_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int NUM_CHAN    = 4;    // motor axes on the board
    localparam int CUR_W       = 16;   // adc / dac current word
    localparam int DATA_W      = 32;   // register data
    localparam int ADDR_W      = 16;   // register address
    localparam int SAFETY_HOLD = 8;    // overcurrent samples before trip

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN    = 4'd0;   // main register space
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;   // channel: current feedback
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;   // channel: current command
    localparam logic [3:0] OFF_STATUS   = 4'd0;   // board: status / control
    localparam logic [3:0] OFF_IDENT    = 4'd4;   // board: ident word

    localparam logic [31:0] BOARD_IDENT = "QLA1";

    typedef logic [CUR_W-1:0]    cur_t;
    typedef logic [NUM_CHAN-1:0] chan_vec_t;

    // addr[15:12] space, addr[7:4] channel, addr[3:0] offset
    typedef struct packed {
        logic [ADDR_W/4-1:0] space;
        logic [ADDR_W/4-1:0] reserved;
        logic [ADDR_W/4-1:0] chan;
        logic [ADDR_W/4-1:0] offset;
    } reg_addr_t;

    // one quadlet write from either host port
    typedef struct packed {
        logic              wen;
        reg_addr_t         waddr;
        logic [DATA_W-1:0] wdata;
    } host_wr_t;

    // write to OFF_STATUS, mask/value pairs
    typedef struct packed {
        logic [11:0] rsvd_hi;
        logic        pwr_mask;   // bit 19
        logic        pwr_val;    // bit 18
        logic [5:0]  rsvd_mid;
        logic [3:0]  amp_mask;   // 11:8, also safety clear mask
        logic [3:0]  rsvd_lo;
        logic [3:0]  amp_val;    // 3:0
    } status_wr_t;

    // read of OFF_STATUS
    typedef struct packed {
        logic [3:0] rsvd_31_28;
        logic [3:0] board_id;       // 27:24
        logic [3:0] rsvd_23_20;
        logic       pwr_enable;     // 19
        logic [6:0] rsvd_18_12;
        logic [3:0] safety_fault;   // 11:8
        logic [3:0] rsvd_7_4;
        logic [3:0] amp_enable;     // 3:0
    } status_rd_t;

endpackage

// ==== hdl/host_bus.sv ====
`timescale 1ns/1ns

module host_bus (
    input  qla_pkg::host_wr_t          fw_wr,         // firewire write request
    input  qla_pkg::reg_addr_t         fw_raddr,      // firewire read address
    input  qla_pkg::host_wr_t          eth_wr,        // ethernet write request
    input  qla_pkg::reg_addr_t         eth_raddr,     // ethernet read address
    input  logic                       eth_read_en,   // ethernet owns the read path
    input  logic [qla_pkg::DATA_W-1:0] board_rdata,   // channel 0 read data
    input  logic [qla_pkg::DATA_W-1:0] chan_rdata,    // channels 1-4 read data
    output qla_pkg::host_wr_t          bus_wr,
    output qla_pkg::reg_addr_t         bus_raddr,
    output logic [qla_pkg::DATA_W-1:0] reg_rdata
);

    // ------------------------------------------------------------------------
    // request merge
    // ------------------------------------------------------------------------

    // ethernet wins, a colliding firewire write is dropped
    assign bus_wr = eth_wr.wen ? eth_wr : fw_wr;

    assign bus_raddr = eth_read_en ? eth_raddr : fw_raddr;   // read side select

    // ------------------------------------------------------------------------
    // read data mux
    // ------------------------------------------------------------------------
    always_comb begin
        reg_rdata = '0;   // other spaces / channels read zero
        if (bus_raddr.space == qla_pkg::ADDR_MAIN) begin
            if (bus_raddr.chan == 4'd0) begin
                reg_rdata = board_rdata;   // board i/o
            end
            else if (bus_raddr.chan <= 4'(qla_pkg::NUM_CHAN)) begin
                reg_rdata = chan_rdata;    // motor axes
            end
        end
    end

endmodule

// ==== hdl/channel_regs.sv ====
`timescale 1ns/1ns

module channel_regs (
    input  logic                       sysclk,
    input  logic                       reset,
    input  qla_pkg::host_wr_t          bus_wr,
    input  qla_pkg::reg_addr_t         bus_raddr,
    input  qla_pkg::cur_t              cur_fb  [qla_pkg::NUM_CHAN],   // adc feedback
    output qla_pkg::cur_t              cur_cmd [qla_pkg::NUM_CHAN],   // dac command
    output logic [qla_pkg::DATA_W-1:0] chan_rdata
);

    localparam logic [qla_pkg::DATA_W-qla_pkg::CUR_W-1:0] PAD = '0;

    logic dac_wen;   // write to some channel's dac register

    assign dac_wen = bus_wr.wen
                  && (bus_wr.waddr.space == qla_pkg::ADDR_MAIN)
                  && (bus_wr.waddr.offset == qla_pkg::OFF_DAC_CTRL);

    // ------------------------------------------------------------------------
    // command registers, axis n lives at index n-1
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < qla_pkg::NUM_CHAN; i++) begin
                cur_cmd[i] <= '0;   // amps off at power-up
            end
        end
        else begin
            for (int i = 0; i < qla_pkg::NUM_CHAN; i++) begin
                if (dac_wen && (bus_wr.waddr.chan == 4'(i + 1))) begin
                    cur_cmd[i] <= bus_wr.wdata[qla_pkg::CUR_W-1:0];   // low half only
                end
            end
        end
    end

    // read back, zero extended
    always_comb begin
        chan_rdata = '0;
        for (int i = 0; i < qla_pkg::NUM_CHAN; i++) begin
            if (bus_raddr.chan == 4'(i + 1)) begin
                if (bus_raddr.offset == qla_pkg::OFF_DAC_CTRL) begin
                    chan_rdata = {PAD, cur_cmd[i]};
                end
                else if (bus_raddr.offset == qla_pkg::OFF_ADC_DATA) begin
                    chan_rdata = {PAD, cur_fb[i]};
                end
            end
        end
    end

endmodule

// ==== hdl/safety_check.sv ====
`timescale 1ns/1ns

module safety_check (
    input  logic          sysclk,
    input  logic          reset,
    input  qla_pkg::cur_t cur_in,   // measured current
    input  qla_pkg::cur_t cmd_in,   // commanded current
    input  logic          clear,    // one-cycle fault clear
    output logic          fault
);

    logic [qla_pkg::CUR_W:0]               limit;      // 2 * cmd, one spare bit
    logic                                  over;       // overcurrent this sample
    logic [$clog2(qla_pkg::SAFETY_HOLD)-1:0] over_cnt;   // consecutive over samples

    assign limit = {cmd_in, 1'b0};
    assign over  = {1'b0, cur_in} > limit;   // equal is still fine

    // ------------------------------------------------------------------------
    // run-length counter and fault latch
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            over_cnt <= '0;
            fault    <= 1'b0;
        end
        else begin
            if (!over) begin
                over_cnt <= '0;   // any good sample restarts the run
            end
            else if (over_cnt != $bits(over_cnt)'(qla_pkg::SAFETY_HOLD - 1)) begin
                over_cnt <= over_cnt + 1'b1;   // saturates at hold - 1
            end

            // clear has priority over a new trip
            if (clear) begin
                fault <= 1'b0;
            end
            else if (over && (over_cnt == $bits(over_cnt)'(qla_pkg::SAFETY_HOLD - 1))) begin
                fault <= 1'b1;   // hold-th sample in a row
            end
        end
    end

endmodule

// ==== hdl/board_regs.sv ====
`timescale 1ns/1ns

module board_regs (
    input  logic                       sysclk,
    input  logic                       reset,
    input  qla_pkg::host_wr_t          bus_wr,
    input  qla_pkg::reg_addr_t         bus_raddr,
    input  logic [3:0]                 board_id,       // rotary switch
    input  qla_pkg::chan_vec_t         safety_fault,   // latched trips per axis
    output logic [qla_pkg::DATA_W-1:0] board_rdata,
    output qla_pkg::chan_vec_t         safety_clear,   // one-cycle pulse
    output qla_pkg::chan_vec_t         amp_enable,
    output logic                       pwr_enable      // amp power supply
);

    qla_pkg::status_wr_t wr_word;       // write data seen as status fields
    qla_pkg::status_rd_t status_word;   // read view
    qla_pkg::chan_vec_t  amp_req;       // host requested amp state
    logic                status_wen;

    assign wr_word = bus_wr.wdata;

    assign status_wen = bus_wr.wen
                     && (bus_wr.waddr.space == qla_pkg::ADDR_MAIN)
                     && (bus_wr.waddr.chan == 4'd0)
                     && (bus_wr.waddr.offset == qla_pkg::OFF_STATUS);

    // ------------------------------------------------------------------------
    // power / amp control
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable   <= 1'b0;
            amp_req      <= '0;
            safety_clear <= '0;
        end
        else begin
            // re-enabling an axis also clears its safety trip
            safety_clear <= status_wen ? (wr_word.amp_mask & wr_word.amp_val) : '0;
            if (status_wen) begin
                if (wr_word.pwr_mask) begin
                    pwr_enable <= wr_word.pwr_val;
                end
                // only masked bits change
                amp_req <= (amp_req & ~wr_word.amp_mask) | (wr_word.amp_val & wr_word.amp_mask);
            end
        end
    end

    // no power or a latched fault forces the amp off
    assign amp_enable = amp_req & ~safety_fault & {qla_pkg::NUM_CHAN{pwr_enable}};

    // ------------------------------------------------------------------------
    // read back
    // ------------------------------------------------------------------------
    always_comb begin
        status_word              = '0;
        status_word.board_id     = board_id;
        status_word.pwr_enable   = pwr_enable;
        status_word.safety_fault = safety_fault;
        status_word.amp_enable   = amp_enable;
    end

    always_comb begin
        board_rdata = '0;
        if (bus_raddr.offset == qla_pkg::OFF_STATUS) begin
            board_rdata = status_word;
        end
        else if (bus_raddr.offset == qla_pkg::OFF_IDENT) begin
            board_rdata = qla_pkg::BOARD_IDENT;   // "QLA1"
        end
    end

endmodule

// ==== hdl/qla_top.sv ====
`timescale 1ns/1ns

module qla_top (
    input  logic                       sysclk,
    input  logic                       reset,
    input  qla_pkg::host_wr_t          fw_wr,
    input  qla_pkg::reg_addr_t         fw_raddr,
    input  qla_pkg::host_wr_t          eth_wr,
    input  qla_pkg::reg_addr_t         eth_raddr,
    input  logic                       eth_read_en,
    input  logic [3:0]                 board_id,
    input  qla_pkg::cur_t              cur_fb  [qla_pkg::NUM_CHAN],
    output logic [qla_pkg::DATA_W-1:0] reg_rdata,
    output qla_pkg::cur_t              cur_cmd [qla_pkg::NUM_CHAN],
    output qla_pkg::chan_vec_t         amp_enable,
    output logic                       pwr_enable
);

    qla_pkg::host_wr_t          bus_wr;         // merged write request
    qla_pkg::reg_addr_t         bus_raddr;      // merged read address
    logic [qla_pkg::DATA_W-1:0] board_rdata;    // channel 0
    logic [qla_pkg::DATA_W-1:0] chan_rdata;     // channels 1-4
    qla_pkg::chan_vec_t         safety_fault;
    qla_pkg::chan_vec_t         safety_clear;

    // ------------------------------------------------------------------------
    // host side
    // ------------------------------------------------------------------------
    host_bus i_host_bus (
        .fw_wr       (fw_wr),
        .fw_raddr    (fw_raddr),
        .eth_wr      (eth_wr),
        .eth_raddr   (eth_raddr),
        .eth_read_en (eth_read_en),
        .board_rdata (board_rdata),
        .chan_rdata  (chan_rdata),
        .bus_wr      (bus_wr),
        .bus_raddr   (bus_raddr),
        .reg_rdata   (reg_rdata)
    );

    channel_regs i_channel_regs (
        .sysclk     (sysclk),
        .reset      (reset),
        .bus_wr     (bus_wr),
        .bus_raddr  (bus_raddr),
        .cur_fb     (cur_fb),
        .cur_cmd    (cur_cmd),
        .chan_rdata (chan_rdata)
    );

    board_regs i_board_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus_wr       (bus_wr),
        .bus_raddr    (bus_raddr),
        .board_id     (board_id),
        .safety_fault (safety_fault),
        .board_rdata  (board_rdata),
        .safety_clear (safety_clear),
        .amp_enable   (amp_enable),
        .pwr_enable   (pwr_enable)
    );

    // one checker per axis, feedback vs twice the command
    for (genvar i = 0; i < qla_pkg::NUM_CHAN; i++) begin : g_safety
        safety_check i_safety_check (
            .sysclk (sysclk),
            .reset  (reset),
            .cur_in (cur_fb[i]),
            .cmd_in (cur_cmd[i]),
            .clear  (safety_clear[i]),
            .fault  (safety_fault[i])
        );
    end

endmodule

// ==== test/tb_qla_top.sv ====
`timescale 1ns/1ns

module tb_qla_top;

    localparam int CLK_PERIOD = 20;
    localparam int N_TESTS    = 5;
    localparam int SETTLE     = CLK_PERIOD / 4;   // sample point after a falling-edge drive
    localparam int HOLD       = qla_pkg::SAFETY_HOLD;

    logic                       sysclk;
    logic                       reset;
    qla_pkg::host_wr_t          fw_wr;
    qla_pkg::reg_addr_t         fw_raddr;
    qla_pkg::host_wr_t          eth_wr;
    qla_pkg::reg_addr_t         eth_raddr;
    logic                       eth_read_en;
    logic [3:0]                 board_id;
    qla_pkg::cur_t              cur_fb  [qla_pkg::NUM_CHAN];
    logic [qla_pkg::DATA_W-1:0] reg_rdata;
    qla_pkg::cur_t              cur_cmd [qla_pkg::NUM_CHAN];
    qla_pkg::chan_vec_t         amp_enable;
    logic                       pwr_enable;

    // reference model of the register state
    qla_pkg::cur_t      exp_cmd [qla_pkg::NUM_CHAN];
    qla_pkg::chan_vec_t exp_req;     // requested amp bits
    qla_pkg::chan_vec_t exp_fault;   // latched trips
    logic               exp_pwr;

    qla_top i_dut (.*);

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // watchdog, 200 cycles per test
    initial begin
        #(N_TESTS * 200 * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d cycles", N_TESTS * 200);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic fail_now(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic qla_pkg::reg_addr_t mk_addr(logic [3:0] space, int chan, logic [3:0] off);
        qla_pkg::reg_addr_t a;
        a        = '0;
        a.space  = space;
        a.chan   = 4'(chan);
        a.offset = off;
        return a;
    endfunction

    function automatic qla_pkg::chan_vec_t exp_amp();
        return exp_pwr ? (exp_req & ~exp_fault) : '0;   // power gates every axis
    endfunction

    function automatic logic [31:0] exp_status();
        qla_pkg::status_rd_t s;
        s              = '0;
        s.board_id     = board_id;
        s.pwr_enable   = exp_pwr;
        s.safety_fault = exp_fault;
        s.amp_enable   = exp_amp();
        return s;
    endfunction

    // one-cycle write strobe, returns after the landing edge
    task automatic host_write(input bit use_eth, input qla_pkg::reg_addr_t a,
                              input logic [31:0] d);
        qla_pkg::host_wr_t req;
        req.wen   = 1'b1;
        req.waddr = a;
        req.wdata = d;
        @(negedge sysclk);
        if (use_eth) eth_wr = req;
        else         fw_wr  = req;
        @(negedge sysclk);
        fw_wr.wen  = 1'b0;
        eth_wr.wen = 1'b0;
    endtask

    task automatic write_cmd(input bit use_eth, input int ch, input qla_pkg::cur_t val);
        host_write(use_eth, mk_addr(qla_pkg::ADDR_MAIN, ch, qla_pkg::OFF_DAC_CTRL), {16'b0, val});
        exp_cmd[ch-1] = val;
    endtask

    task automatic write_status(input bit use_eth, input logic pm, input logic pv,
                                input qla_pkg::chan_vec_t am, input qla_pkg::chan_vec_t av);
        qla_pkg::status_wr_t w;
        w          = '0;
        w.pwr_mask = pm;
        w.pwr_val  = pv;
        w.amp_mask = am;
        w.amp_val  = av;
        host_write(use_eth, mk_addr(qla_pkg::ADDR_MAIN, 0, qla_pkg::OFF_STATUS), w);
        if (pm) exp_pwr = pv;
        exp_req = (exp_req & ~am) | (av & am);   // masked bits only
    endtask

    task automatic read_check(input bit use_eth, input qla_pkg::reg_addr_t a,
                              input logic [31:0] exp, input string what);
        @(negedge sysclk);
        eth_read_en = use_eth;
        if (use_eth) eth_raddr = a;
        else         fw_raddr  = a;
        #(SETTLE);
        assert (reg_rdata == exp)
            else fail_now($sformatf("%s: read %h, expected %h", what, reg_rdata, exp));
    endtask

    task automatic check_outputs(input string what);
        for (int i = 0; i < qla_pkg::NUM_CHAN; i++) begin
            assert (cur_cmd[i] == exp_cmd[i])
                else fail_now($sformatf("%s: cur_cmd[%0d] %h, expected %h",
                                        what, i, cur_cmd[i], exp_cmd[i]));
        end
        assert (pwr_enable == exp_pwr)
            else fail_now($sformatf("%s: pwr_enable %b, expected %b", what, pwr_enable, exp_pwr));
        assert (amp_enable == exp_amp())
            else fail_now($sformatf("%s: amp_enable %b, expected %b", what, amp_enable, exp_amp()));
    endtask

    // ------------------------------------------------------------------------
    // properties checked on every edge
    // ------------------------------------------------------------------------
    assert property (@(posedge sysclk) disable iff (reset) pwr_enable || (amp_enable == '0))
        else fail_now("amp_enable active while pwr_enable is low");

    assert property (@(posedge sysclk) disable iff (reset)
        ((eth_read_en ? eth_raddr.space : fw_raddr.space) == qla_pkg::ADDR_MAIN)
        || (reg_rdata == '0))
        else fail_now("read outside the main space returned nonzero data");

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        int            seed;
        int            lim;
        bit            use_eth;
        qla_pkg::cur_t val;
        qla_pkg::cur_t over;

        seed        = $urandom(32'he346);
        reset       = 1'b1;
        fw_wr       = '0;
        eth_wr      = '0;
        fw_raddr    = '0;
        eth_raddr   = '0;
        eth_read_en = 1'b0;
        board_id    = 4'hA;
        exp_req     = '0;
        exp_fault   = '0;
        exp_pwr     = 1'b0;
        for (int i = 0; i < qla_pkg::NUM_CHAN; i++) begin
            cur_fb[i]  = '0;
            exp_cmd[i] = '0;
        end
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        // 1: reset state and ident
        check_outputs("after reset");
        read_check(1'b0, mk_addr(qla_pkg::ADDR_MAIN, 0, qla_pkg::OFF_STATUS), exp_status(),
                   "status after reset");
        read_check(1'b1, mk_addr(qla_pkg::ADDR_MAIN, 0, qla_pkg::OFF_IDENT), "QLA1", "ident");

        // 2: random commands through both ports, feedback kept at or below 2x
        for (int r = 0; r < 2; r++) begin
            for (int ch = 1; ch <= qla_pkg::NUM_CHAN; ch++) begin
                use_eth = ((ch + r) % 2) == 1;
                val     = 16'($urandom);
                @(negedge sysclk);
                cur_fb[ch-1] = '0;
                write_cmd(use_eth, ch, val);
                check_outputs("command write");
                read_check(!use_eth, mk_addr(qla_pkg::ADDR_MAIN, ch, qla_pkg::OFF_DAC_CTRL),
                           {16'b0, val}, "dac readback");
                lim = 2 * int'(val);
                if (lim > 65535) lim = 65535;
                @(negedge sysclk);
                cur_fb[ch-1] = 16'($urandom_range(lim));
                read_check(use_eth, mk_addr(qla_pkg::ADDR_MAIN, ch, qla_pkg::OFF_ADC_DATA),
                           {16'b0, cur_fb[ch-1]}, "adc readback");
            end
        end
        read_check(1'b0, mk_addr(qla_pkg::ADDR_MAIN, 5, qla_pkg::OFF_DAC_CTRL), '0, "channel 5");
        read_check(1'b1, mk_addr(4'd1, 1, qla_pkg::OFF_DAC_CTRL), '0, "space 1");
        read_check(1'b0, mk_addr(qla_pkg::ADDR_MAIN, 2, 4'd7), '0, "unused offset");
        @(negedge sysclk);
        for (int i = 0; i < qla_pkg::NUM_CHAN; i++) cur_fb[i] = '0;

        // 3: write collision, ethernet wins
        val = 16'($urandom);
        @(negedge sysclk);
        fw_wr.wen    = 1'b1;
        fw_wr.waddr  = mk_addr(qla_pkg::ADDR_MAIN, 1, qla_pkg::OFF_DAC_CTRL);
        fw_wr.wdata  = {16'b0, ~exp_cmd[0]};
        eth_wr.wen   = 1'b1;
        eth_wr.waddr = mk_addr(qla_pkg::ADDR_MAIN, 2, qla_pkg::OFF_DAC_CTRL);
        eth_wr.wdata = {16'b0, val};
        @(negedge sysclk);
        fw_wr.wen  = 1'b0;
        eth_wr.wen = 1'b0;
        exp_cmd[1] = val;
        check_outputs("write collision");
        // read side follows eth_read_en
        @(negedge sysclk);
        fw_raddr    = mk_addr(qla_pkg::ADDR_MAIN, 1, qla_pkg::OFF_DAC_CTRL);
        eth_raddr   = mk_addr(qla_pkg::ADDR_MAIN, 2, qla_pkg::OFF_DAC_CTRL);
        eth_read_en = 1'b1;
        #(SETTLE);
        assert (reg_rdata == {16'b0, exp_cmd[1]})
            else fail_now($sformatf("eth read select: read %h", reg_rdata));
        @(negedge sysclk);
        eth_read_en = 1'b0;
        #(SETTLE);
        assert (reg_rdata == {16'b0, exp_cmd[0]})
            else fail_now($sformatf("fw read select: read %h", reg_rdata));

        // 4: power and amp enables
        write_status(1'b0, 1'b0, 1'b1, 4'hF, 4'hF);   // amps requested, no power
        check_outputs("amp request without power");
        write_status(1'b1, 1'b1, 1'b1, 4'h0, 4'h0);
        check_outputs("power on");
        write_status(1'b0, 1'b0, 1'b0, 4'b0101, 4'b0000);
        check_outputs("amp 0 and 2 off");
        write_status(1'b1, 1'b0, 1'b0, 4'b0001, 4'b0001);
        check_outputs("amp 0 on");
        write_status(1'b0, 1'b1, 1'b0, 4'h0, 4'h0);
        check_outputs("power off");
        write_status(1'b1, 1'b1, 1'b1, 4'hF, 4'hF);
        check_outputs("all on");
        read_check(1'b0, mk_addr(qla_pkg::ADDR_MAIN, 0, qla_pkg::OFF_STATUS), exp_status(),
                   "status all on");

        // 5: safety trip and clear, 2x cmd + 1 must fit in 16 bits
        for (int ch = 1; ch <= qla_pkg::NUM_CHAN; ch++) begin
            write_cmd(ch[0], ch, 16'($urandom_range(16383, 256)));
        end
        @(negedge sysclk);
        cur_fb[1] = exp_cmd[1] << 1;   // exactly at the limit
        repeat (2 * HOLD) @(negedge sysclk);
        check_outputs("feedback equal to twice the command");
        cur_fb[1] = '0;
        over      = (exp_cmd[2] << 1) + 16'd1;
        cur_fb[2] = over;
        repeat (HOLD - 1) @(negedge sysclk);
        cur_fb[2] = '0;                // broken run restarts the count
        @(negedge sysclk);
        check_outputs("short overcurrent burst");
        cur_fb[2] = over;
        repeat (HOLD - 1) @(negedge sysclk);
        check_outputs("one sample short of a trip");
        @(negedge sysclk);
        exp_fault = 4'b0100;
        check_outputs("overcurrent trip");
        read_check(1'b1, mk_addr(qla_pkg::ADDR_MAIN, 0, qla_pkg::OFF_STATUS), exp_status(),
                   "status after trip");
        @(negedge sysclk);
        cur_fb[2] = '0;
        repeat (3) @(negedge sysclk);
        check_outputs("fault held after overcurrent removed");
        write_status(1'b1, 1'b0, 1'b0, 4'b0100, 4'b0100);
        check_outputs("clear pulse in flight");
        @(negedge sysclk);
        exp_fault = '0;
        check_outputs("fault cleared");
        read_check(1'b0, mk_addr(qla_pkg::ADDR_MAIN, 0, qla_pkg::OFF_STATUS), exp_status(),
                   "status after clear");

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/qla_pkg.sv
hdl/host_bus.sv
hdl/channel_regs.sv
hdl/safety_check.sv
hdl/board_regs.sv
hdl/qla_top.sv
test/tb_qla_top.sv

// ==== Makefile ====
# Verilator simulation of the register-bus core
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_qla_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
